//--- files.f
+incdir+include
source/memPkg.sv
source/strPkg.sv
source/syncFifo.sv
source/readArbiter.sv
source/offsetFetcher.sv
source/stringFetcher.sv
source/lineAligner.sv
source/strReadTop.sv
testbench/tbStrRead.sv

//--- run.sh
#!/bin/sh
# build and run the string reader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tbStrRead -Mdir obj_dir -o simStrRead
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simStrRead > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" sim.log; then
	exit 0
fi
exit 1

//--- testbench/tbStrRead.sv
module tbStrRead;
	import memPkg::*;
	import strPkg::*;

	localparam int nRows = 5;
	localparam int heapSize = 4096; // bytes in the heap model
	localparam int doneLimit = 20000;
	localparam int drainLimit = 1000;
	localparam lineAddrT offBase = 58'h100; // offset array line
	localparam lineAddrT heapBase = 58'h2000;

	// case table, the length pattern repeats over the strings
	string rowName [nRows] = '{"oneShort", "unaligned", "manyStrings", "readyGaps", "emptyRun"};
	int rowBat [nRows] = '{1, 3, 37, 37, 0};
	int rowLens [nRows][4] = '{'{8, 8, 8, 8}, '{200, 0, 60, 132}, '{12, 100, 0, 64},
		'{12, 100, 0, 64}, '{4, 4, 4, 4}};
	int rowAlign [nRows] = '{4, 20, 8, 8, 0}; // first offset
	int rowDuty [nRows] = '{100, 100, 100, 40, 100}; // strReady high, percent
	int rowRef [nRows] = '{-1, -1, -1, 2, -1}; // row with identical data
	int rowBeats [nRows] = '{1, 6, 46, 46, 0}; // worked out by hand

	logic clk;
	logic rst;
	logic go;
	lineAddrT baseAddr;
	lineAddrT vbaseAddr;
	logic [31:0] batCount;
	logic readReqReady;
	logic respValid;
	readRespT readResp;
	logic strReady;
	logic readReqValid;
	readReqT readReq;
	logic strValid;
	beatT strOut;
	logic done;

	logic [7:0] heap [heapSize];
	heapOffT offs [64];
	int offLines;
	int heapLines;
	int duty;
	int curRow;
	beatT expQ [$]; // beats still owed by the DUT
	readReqT reqQ [$]; // accepted, not yet answered
	int dueQ [$];
	int lastDue = 0;
	int cycle = 0;
	int unsigned timeSt = 78074; // delays and ready gaps
	int errors = 0;
	int checks = 0;
	int gotBeats;
	logic [512:0] sig; // rolling xor of received beats
	logic [512:0] rowSig [nRows];

	strReadTop uut (
		.clk(clk), .rst(rst), .go(go),
		.baseAddr(baseAddr), .vbaseAddr(vbaseAddr), .batCount(batCount),
		.readReqReady(readReqReady), .respValid(respValid), .readResp(readResp),
		.strReady(strReady),
		.readReqValid(readReqValid), .readReq(readReq),
		.strValid(strValid), .strOut(strOut), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int unsigned lcg(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function int unsigned drawTime();
		timeSt = lcg(timeSt);
		return timeSt >> 16; // upper bits are the random ones
	endfunction

	// what memory holds at a line address
	function automatic lineT lineData(input lineAddrT a);
		lineT d;
		int rel;
		d = '0;
		if (a >= offBase && a < offBase + lineAddrT'(offLines)) begin
			rel = int'(a - offBase);
			for (int w = 0; w < 16; w++) d[32*w +: 32] = offs[16*rel + w];
		end else if (a >= heapBase && a < heapBase + lineAddrT'(heapLines)) begin
			rel = int'(a - heapBase);
			for (int b = 0; b < 64; b++) d[8*b +: 8] = heap[64*rel + b];
		end
		return d;
	endfunction

	// heap, offsets and expected beats for one row
	task automatic buildRow(input int r);
		int unsigned st;
		int len;
		int n;
		beatT b;
		st = 78074; // same heap for rows with the same lengths
		for (int i = 0; i < 64; i++) offs[i] = '0;
		offs[0] = heapOffT'(rowAlign[r]);
		for (int i = 0; i < rowBat[r]; i++) offs[i+1] = offs[i] + heapOffT'(rowLens[r][i % 4]);
		offLines = (rowBat[r] + 16) / 16; // batCount+1 offsets
		heapLines = int'(offs[rowBat[r]]) / 64 + 2; // spare line for alignment
		for (int i = 0; i < heapLines * 64; i++) begin
			st = lcg(st);
			heap[i] = st[23:16];
		end
		expQ.delete();
		for (int i = 0; i < rowBat[r]; i++) begin
			len = int'(offs[i+1] - offs[i]);
			n = (len + 63) / 64;
			if (n == 0) n = 1; // an empty string still leaves one beat
			for (int k = 0; k < n; k++) begin
				for (int j = 0; j < 64; j++) b.data[8*j +: 8] = heap[int'(offs[i]) + 64*k + j];
				b.last = (k == n - 1);
				expQ.push_back(b);
			end
		end
	endtask

	task automatic checkAddr(input readReqT q);
		logic ok;
		if (q.tag == tagOffset) ok = q.addr >= offBase && q.addr < offBase + lineAddrT'(offLines);
		else ok = q.addr >= heapBase && q.addr < heapBase + lineAddrT'(heapLines);
		checks++;
		if (!ok) begin
			errors++;
			$display("%s: read request to line %h (tag %0d) is outside the offset array and heap",
				rowName[curRow], q.addr, q.tag);
		end
	endtask

	task automatic checkBeat();
		beatT exp;
		gotBeats++;
		sig = {sig[511:0], sig[512]} ^ strOut;
		checks++;
		if (expQ.size() == 0) begin
			errors++;
			$display("%s: a beat came out after every string was delivered", rowName[curRow]);
		end else begin
			exp = expQ.pop_front();
			if (strOut !== exp) begin
				errors++;
				$display("FAILED %s beat %0d: expected %h actual %h",
					rowName[curRow], gotBeats - 1, exp, strOut);
			end
		end
	endtask

	// memory model and output monitor
	initial begin
		readReqT accReq;
		logic accepted;
		int lat;
		forever begin
			@(negedge clk); // everything settled, sample here
			accepted = readReqValid && readReqReady && !rst;
			accReq = readReq;
			if (!rst && strValid && strReady) checkBeat();
			@(posedge clk);
			#1;
			cycle++;
			if (accepted) begin
				checkAddr(accReq);
				lat = cycle + 1 + int'(drawTime() % 8);
				if (lat <= lastDue) lat = lastDue + 1; // answers keep request order
				lastDue = lat;
				reqQ.push_back(accReq);
				dueQ.push_back(lat);
			end
			respValid = 1'b0; // single-cycle strobe
			if (reqQ.size() != 0 && dueQ[0] <= cycle) begin
				readResp = '{data: lineData(reqQ[0].addr), tag: reqQ[0].tag};
				respValid = 1'b1;
				void'(reqQ.pop_front());
				void'(dueQ.pop_front());
			end
			readReqReady = (drawTime() % 100) < 70;
			strReady = int'(drawTime() % 100) < duty;
		end
	end

	initial begin
		int waited;
		logic ok;
		rst = 1'b1;
		go = 1'b0;
		baseAddr = offBase;
		vbaseAddr = heapBase;
		batCount = '0;
		readReqReady = 1'b0;
		respValid = 1'b0;
		readResp = '0;
		strReady = 1'b0;
		duty = 100;
		curRow = 0;
		offLines = 0;
		heapLines = 0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		// no go yet, so nothing may move
		repeat (20) begin
			@(negedge clk);
			checks++;
			if (readReqValid || strValid || done) begin
				errors++;
				$display("outputs went active after reset without a go pulse");
			end
		end
		ok = 1'b1;
		for (int r = 0; r < nRows && ok; r++) begin
			curRow = r;
			buildRow(r);
			duty = rowDuty[r];
			gotBeats = 0;
			sig = '0;
			@(posedge clk);
			#1;
			batCount = rowBat[r];
			go = 1'b1;
			@(posedge clk);
			#1;
			go = 1'b0;
			@(negedge clk);
			checks++;
			if (done !== (rowBat[r] == 0)) begin
				errors++;
				$display("FAILED %s done after go: expected %0d actual %0d",
					rowName[r], rowBat[r] == 0, done);
			end
			waited = 0;
			while (!done && waited < doneLimit) begin
				@(negedge clk);
				waited++;
			end
			if (!done) begin
				errors++;
				ok = 1'b0;
				$display("%s: done never rose, timed out after %0d cycles", rowName[r], waited);
			end else begin
				waited = 0; // let memory finish before the heap changes
				while (reqQ.size() != 0 && waited < drainLimit) begin
					@(negedge clk);
					waited++;
				end
				if (reqQ.size() != 0) begin
					errors++;
					ok = 1'b0;
					$display("%s: memory still owed responses after done", rowName[r]);
				end
				checks++;
				if (gotBeats != rowBeats[r] || expQ.size() != 0) begin
					errors++;
					$display("FAILED %s beat count: expected %0d actual %0d",
						rowName[r], rowBeats[r], gotBeats);
				end
				rowSig[r] = sig;
				if (rowRef[r] >= 0) begin
					checks++;
					if (sig !== rowSig[rowRef[r]]) begin
						errors++;
						$display("FAILED %s data signature: expected %h actual %h",
							rowName[r], rowSig[rowRef[r]], sig);
					end
				end
			end
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- source/strReadTop.sv
`include "strReader_macros.svh"

module strReadTop (
	input logic clk,
	input logic rst,
	input logic go,
	input memPkg::lineAddrT baseAddr,
	input memPkg::lineAddrT vbaseAddr,
	input logic [31:0] batCount,
	input logic readReqReady,
	input logic respValid,
	input memPkg::readRespT readResp,
	input logic strReady,
	output logic readReqValid,
	output memPkg::readReqT readReq,
	output logic strValid,
	output strPkg::beatT strOut,
	output logic done
);
	import memPkg::*;
	import strPkg::*;

	logic offReq;
	lineAddrT offAddr;
	logic offGrant;
	logic strReq;
	lineAddrT strAddr;
	logic strGrant;
	offPairT pair;
	logic pairValid;
	logic pairTake;
	logic metaPush;
	strMetaT meta;
	logic metaAlmostFull;
	logic beatValid;
	beatT beat;
	logic outEmpty;
	logic outAlmostFull;
	logic [31:0] batCnt; // strings in this run
	logic [31:0] lastCnt; // strings fully delivered
	logic lastBeat;

	readArbiter arb (
		.clk(clk), .rst(rst),
		.offReq(offReq), .offAddr(offAddr),
		.strReq(strReq), .strAddr(strAddr),
		.readReqReady(readReqReady),
		.offGrant(offGrant), .strGrant(strGrant),
		.readReqValid(readReqValid), .readReq(readReq)
	);

	offsetFetcher offFetch (
		.clk(clk), .rst(rst), .go(go),
		.baseAddr(baseAddr), .batCount(batCount),
		.offGrant(offGrant), .respValid(respValid), .readResp(readResp),
		.pairTake(pairTake),
		.offReq(offReq), .offAddr(offAddr),
		.pair(pair), .pairValid(pairValid)
	);

	stringFetcher strFetch (
		.clk(clk), .rst(rst), .go(go),
		.vbaseAddr(vbaseAddr), .pair(pair), .pairValid(pairValid),
		.strGrant(strGrant), .respValid(respValid), .readResp(readResp),
		.outAlmostFull(outAlmostFull), .metaAlmostFull(metaAlmostFull),
		.pairTake(pairTake), .strReq(strReq), .strAddr(strAddr),
		.metaPush(metaPush), .meta(meta)
	);

	lineAligner aligner (
		.clk(clk), .rst(rst),
		.respValid(respValid), .readResp(readResp),
		.metaPush(metaPush), .meta(meta),
		.metaAlmostFull(metaAlmostFull),
		.beatValid(beatValid), .beat(beat)
	);

	// headroom for every beat still owed by memory
	syncFifo #(
		.WIDTH($bits(beatT)),
		.DEPTH(`OUT_DEPTH),
		.AF_LEVEL(`OUT_DEPTH - `MAX_INFLIGHT)
	) outFifo (
		.clk(clk), .rst(rst),
		.push(beatValid), .pushData(beat),
		.pop(strValid && strReady), .popData(strOut),
		.empty(outEmpty), .almostFull(outAlmostFull)
	);

	assign strValid = !outEmpty;
	assign lastBeat = strValid && strReady && strOut.last;

	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
			batCnt <= '0;
			lastCnt <= '0;
		end else if (go) begin
			done <= (batCount == '0); // nothing to read
			batCnt <= batCount;
			lastCnt <= '0;
		end else if (lastBeat) begin
			lastCnt <= lastCnt + 1'b1;
			if (lastCnt + 1'b1 == batCnt) done <= 1'b1; // sticky until next go
		end
	end

	// every beat has left by the time the run reports done
	drainedAtDone: assert property (@(posedge clk) disable iff (rst)
		$rose(done) |-> !strValid)
		else $error("done raised with beats still queued");

endmodule

//--- source/lineAligner.sv
`include "strReader_macros.svh"

module lineAligner (
	input logic clk,
	input logic rst,
	input logic respValid,
	input memPkg::readRespT readResp,
	input logic metaPush,
	input strPkg::strMetaT meta,
	output logic metaAlmostFull,
	output logic beatValid,
	output strPkg::beatT beat
);
	import memPkg::*;
	import strPkg::*;

	strMetaT headMeta; // entry of the oldest request
	logic strResp;
	lineT heldLine; // previous line of the same string
	logic [2*$bits(lineT)-1:0] window;

	// leaves MAX_INFLIGHT slots for requests already granted
	syncFifo #(
		.WIDTH($bits(strMetaT)),
		.DEPTH(`META_DEPTH),
		.AF_LEVEL(`META_DEPTH - `MAX_INFLIGHT)
	) metaFifo (
		.clk(clk),
		.rst(rst),
		.push(metaPush),
		.pushData(meta),
		.pop(strResp),
		.popData(headMeta),
		.empty(),
		.almostFull(metaAlmostFull)
	);

	assign strResp = respValid && (readResp.tag == tagString);

	// new line on top, held line below, drop wordOff words
	assign window = {readResp.data, heldLine} >> {headMeta.wordOff, 5'b00000};

	always_ff @(posedge clk) begin
		if (rst) begin
			beatValid <= 1'b0;
		end else begin
			beatValid <= strResp && !headMeta.first; // leading line gives no beat
		end
	end

	always_ff @(posedge clk) begin
		if (strResp) begin
			heldLine <= readResp.data;
			beat.data <= window[$bits(lineT)-1:0];
			beat.last <= headMeta.lastLine;
		end
	end

endmodule

//--- source/stringFetcher.sv
`include "strReader_macros.svh"

module stringFetcher (
	input logic clk,
	input logic rst,
	input logic go,
	input memPkg::lineAddrT vbaseAddr,
	input strPkg::offPairT pair,
	input logic pairValid,
	input logic strGrant,
	input logic respValid,
	input memPkg::readRespT readResp,
	input logic outAlmostFull,
	input logic metaAlmostFull,
	output logic pairTake,
	output logic strReq,
	output memPkg::lineAddrT strAddr,
	output logic metaPush,
	output strPkg::strMetaT meta
);
	import memPkg::*;
	import strPkg::*;

	localparam int flightW = $clog2(`MAX_INFLIGHT + 1);

	typedef enum logic [1:0] {
		idle,
		newString, // first heap line of the string
		moreLines // remaining lines incl. the alignment spare
	} stateT;

	stateT state;
	lineAddrT vbase; // heap base for this run
	lineAddrT curAddr; // next heap line to request
	wordOffT wordOff;
	logic [26:0] linesLeft; // requests after the first one
	logic [flightW-1:0] inFlight;
	logic reqHeld; // request raised but not granted yet
	logic canIssue;
	logic strResp;
	heapOffT strLen;
	logic [26:0] beatCnt;

	assign strLen = pair.stop - pair.start;
	// beats = whole lines of payload, at least one
	assign beatCnt = (strLen == '0) ? 27'd1 : 27'(({1'b0, strLen} + 33'd63) >> 6);

	assign pairTake = (state == idle) && pairValid;

	// room downstream for every answer still owed
	assign canIssue = !outAlmostFull && !metaAlmostFull &&
		(inFlight < flightW'(`MAX_INFLIGHT));
	assign strReq = (state != idle) && (canIssue || reqHeld);
	assign strAddr = curAddr;

	assign metaPush = strGrant; // one entry per accepted request
	assign meta = '{
		first: (state == newString),
		wordOff: wordOff,
		lastLine: (state == moreLines) && (linesLeft == 27'd1)
	};

	assign strResp = respValid && (readResp.tag == tagString);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			inFlight <= '0;
			reqHeld <= 1'b0;
			vbase <= '0;
		end else begin
			if (go) vbase <= vbaseAddr;
			reqHeld <= strReq && !strGrant;
			inFlight <= inFlight + flightW'(strGrant) - flightW'(strResp);
			case (state)
				idle: begin
					if (pairTake) state <= newString;
				end
				newString: begin
					if (strGrant) state <= moreLines;
				end
				moreLines: begin
					if (strGrant && linesLeft == 27'd1) state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pairTake) begin
			curAddr <= vbase + lineAddrT'(pair.start[31:6]);
			wordOff <= pair.start[5:2]; // 4-byte granularity
			linesLeft <= beatCnt; // n beats need n+1 lines
		end else if (strGrant) begin
			curAddr <= curAddr + 1'b1;
			if (state == moreLines) linesLeft <= linesLeft - 1'b1;
		end
	end

	// memory answers only what was granted here
	noStrayResp: assert property (@(posedge clk) disable iff (rst)
		strResp |-> inFlight != '0)
		else $error("string response without request in flight");

endmodule

//--- source/offsetFetcher.sv
`include "strReader_macros.svh"

module offsetFetcher (
	input logic clk,
	input logic rst,
	input logic go,
	input memPkg::lineAddrT baseAddr,
	input logic [31:0] batCount,
	input logic offGrant,
	input logic respValid,
	input memPkg::readRespT readResp,
	input logic pairTake,
	output logic offReq,
	output memPkg::lineAddrT offAddr,
	output strPkg::offPairT pair,
	output logic pairValid
);
	import memPkg::*;
	import strPkg::*;

	localparam int occW = $clog2(`OFFBUF_DEPTH + 1);

	logic [31:0] reqLeft; // offset lines still to request
	logic [31:0] pairsLeft; // pairs still to hand out
	logic [occW-1:0] occ; // lines buffered plus in flight
	lineAddrT reqAddr;
	logic primed; // prevOff holds the next start
	heapOffT prevOff;
	wordOffT idx; // offset slot in the head line
	lineT headLine;
	logic lineEmpty;
	logic linePush;
	logic linePop;
	logic primeStep; // swallow offset 0 once per run
	logic step; // one offset consumed
	heapOffT curOff;

	syncFifo #(
		.WIDTH($bits(lineT)),
		.DEPTH(`OFFBUF_DEPTH),
		.AF_LEVEL(`OFFBUF_DEPTH)
	) lineBuf (
		.clk(clk),
		.rst(rst),
		.push(linePush),
		.pushData(readResp.data),
		.pop(linePop),
		.popData(headLine),
		.empty(lineEmpty),
		.almostFull()
	);

	assign linePush = respValid && (readResp.tag == tagOffset);
	assign curOff = headLine[{idx, 5'b00000} +: 32];

	assign offReq = (reqLeft != '0) && (occ < occW'(`OFFBUF_DEPTH)); // credit check
	assign offAddr = reqAddr;

	assign pairValid = primed && !lineEmpty && (pairsLeft != '0);
	assign pair = '{start: prevOff, stop: curOff};

	assign primeStep = !primed && !lineEmpty && (pairsLeft != '0);
	assign step = primeStep || pairTake;
	// drop the head at its last slot or after the final pair
	assign linePop = step && ((idx == wordOffT'(`OFFS_PER_LINE - 1)) ||
		(pairTake && pairsLeft == 32'd1));

	always_ff @(posedge clk) begin
		if (rst) begin
			reqLeft <= '0;
			pairsLeft <= '0;
			occ <= '0;
			reqAddr <= '0;
			primed <= 1'b0;
			idx <= '0;
		end else begin
			if (go) begin
				// batCount+1 offsets, rounded up to whole lines
				reqLeft <= (batCount == '0) ? '0 :
					32'(({1'b0, batCount} + 33'(`OFFS_PER_LINE)) / `OFFS_PER_LINE);
				pairsLeft <= batCount;
				reqAddr <= baseAddr;
				primed <= 1'b0;
				idx <= '0;
			end else begin
				if (offGrant) begin
					reqLeft <= reqLeft - 1'b1;
					reqAddr <= reqAddr + 1'b1; // address order
				end
				if (primeStep) primed <= 1'b1;
				if (step) idx <= idx + 1'b1; // wraps into the next line
				if (pairTake) begin
					pairsLeft <= pairsLeft - 1'b1;
					if (pairsLeft == 32'd1) begin
						primed <= 1'b0; // run over
						idx <= '0;
					end
				end
			end
			occ <= occ + occW'(offGrant) - occW'(linePop);
		end
	end

	// last offset of a line carries over as the next start
	always_ff @(posedge clk) begin
		if (step) prevOff <= curOff;
	end

endmodule

//--- source/readArbiter.sv
module readArbiter (
	input logic clk,
	input logic rst,
	input logic offReq,
	input memPkg::lineAddrT offAddr,
	input logic strReq,
	input memPkg::lineAddrT strAddr,
	input logic readReqReady,
	output logic offGrant,
	output logic strGrant,
	output logic readReqValid,
	output memPkg::readReqT readReq
);
	import memPkg::*;

	logic prioStr; // string side wins the next tie
	logic lockValid; // port holds an unaccepted request
	logic lockStr; // which side that request came from
	logic pickStr;
	logic fire;

	// a waiting request keeps its owner until the handshake
	assign pickStr = lockValid ? lockStr : (strReq && (!offReq || prioStr));
	assign readReqValid = offReq || strReq;
	assign fire = readReqValid && readReqReady;

	assign readReq = '{
		addr: pickStr ? strAddr : offAddr,
		tag: pickStr ? tagString : tagOffset
	};

	assign offGrant = fire && !pickStr; // same-cycle grant
	assign strGrant = fire && pickStr;

	always_ff @(posedge clk) begin
		if (rst) begin
			prioStr <= 1'b0;
			lockValid <= 1'b0;
			lockStr <= 1'b0;
		end else begin
			lockValid <= readReqValid && !readReqReady;
			lockStr <= pickStr;
			if (fire) prioStr <= !pickStr; // loser goes first next time
		end
	end

	// locked owner must still be asking when its grant arrives
	grantToRequester: assert property (@(posedge clk) disable iff (rst)
		!(offGrant && !offReq) && !(strGrant && !strReq))
		else $error("grant given to a side that is not requesting");

	// requesters must hold address and valid while waiting
	holdRequest: assert property (@(posedge clk) disable iff (rst)
		readReqValid && !readReqReady |=> readReqValid && $stable(readReq))
		else $error("read request changed before ready");

endmodule

//--- source/syncFifo.sv
module syncFifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16,
	parameter int AF_LEVEL = DEPTH - 2
) (
	input logic clk,
	input logic rst,
	input logic push,
	input logic [WIDTH-1:0] pushData,
	input logic pop,
	output logic [WIDTH-1:0] popData,
	output logic empty,
	output logic almostFull
);
	localparam int ptrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int cntW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count; // entries held

	// wrap at DEPTH, not only at powers of two
	function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
		return (ptr == ptrW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign popData = mem[rdPtr]; // show-ahead read
	assign empty = (count == '0);
	assign almostFull = (count >= cntW'(AF_LEVEL));

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) wrPtr <= nextPtr(wrPtr);
			if (pop) rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// writers rely on their own credit schemes
	noOverflow: assert property (@(posedge clk) disable iff (rst)
		push |-> count != cntW'(DEPTH))
		else $error("syncFifo push while full");

	noUnderflow: assert property (@(posedge clk) disable iff (rst)
		pop |-> !empty)
		else $error("syncFifo pop while empty");

endmodule

//--- source/strPkg.sv
package strPkg;

	typedef logic [31:0] heapOffT; // byte offset into the heap
	typedef logic [3:0] wordOffT; // 32-bit word within a line

	// one string as two neighbouring offsets
	typedef struct packed {
		heapOffT start;
		heapOffT stop; // one past the last byte
	} offPairT;

	// travels from request to response
	typedef struct packed {
		logic first; // leading line only fills the holder
		wordOffT wordOff; // shift in words
		logic lastLine; // last request of the string
	} strMetaT;

	typedef struct packed {
		memPkg::lineT data;
		logic last;
	} beatT;

	// beats per string follow the length in whole lines
	// an empty string still gives one beat

endpackage

//--- source/memPkg.sv
`include "strReader_macros.svh"

package memPkg;

	typedef logic [`LINE_BYTES*8-1:0] lineT; // byte b sits at bits 8b+7:8b
	typedef logic [57:0] lineAddrT; // byte address / 64

	// response routing
	typedef logic reqTagT;

	localparam reqTagT tagOffset = 1'b0;
	localparam reqTagT tagString = 1'b1;

	typedef struct packed {
		lineAddrT addr;
		reqTagT tag;
	} readReqT;

	typedef struct packed {
		lineT data;
		reqTagT tag; // echoed from the request
	} readRespT;

endpackage

//--- include/strReader_macros.svh
`ifndef STR_READER_MACROS_SVH
`define STR_READER_MACROS_SVH

// cache line geometry
`define LINE_BYTES 64
`define OFFS_PER_LINE 16 // 4-byte offsets per line

// offset lines buffered plus still in flight
`define OFFBUF_DEPTH 4

`define META_DEPTH 64 // one entry per string line request
`define OUT_DEPTH 64 // aligned beats waiting for the sink

// string line requests allowed without a response
`define MAX_INFLIGHT 16

`endif
